/* Bender.yml */
package:
  name: periph_bridge

sources:
  - logic/periph_pkg.sv
  - logic/bus_decode.sv
  - logic/gpio_regs.sv
  - logic/edge_count_byte.sv
  - logic/pwm_byte.sv
  - logic/read_return.sv
  - logic/pin_mux.sv
  - logic/periph_top.sv
  - target: test
    files:
      - sim/periph_tb.sv

/* compile.f */
logic/periph_pkg.sv
logic/bus_decode.sv
logic/gpio_regs.sv
logic/edge_count_byte.sv
logic/pwm_byte.sv
logic/read_return.sv
logic/pin_mux.sv
logic/periph_top.sv
sim/periph_tb.sv

/* logic/bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
    input  periph_pkg::bus_req_t  i_req,
    input  logic                  i_busy,
    output periph_pkg::slot_sel_t o_sel
);

    periph_pkg::slot_idx_t simple_idx;
    periph_pkg::slot_idx_t full_idx;
    logic                  is_simple;
    logic                  is_full;

    // Address map
    // 0x000-0x3ff  sixteen 64-byte full slots
    // 0x400-0x4ff  sixteen 16-byte simple slots
    // 0x600-0x7ff  unmapped
    assign simple_idx = i_req.addr[7:4];
    assign full_idx   = i_req.addr[9:6];
    assign is_simple  = (i_req.addr[10:9] == 2'b10);
    assign is_full    = !i_req.addr[10];

    always_comb begin
        o_sel = '0;
        if (is_simple) begin
            o_sel.simple[simple_idx] = 1'b1;
        end else if (is_full) begin
            o_sel.full[full_idx] = 1'b1;
        end

        o_sel.write = (i_req.write_size != periph_pkg::ACC_NONE);
        // No second read reaches a slot until the held answer is taken
        o_sel.read  = (i_req.read_size != periph_pkg::ACC_NONE) && !i_busy;
        o_sel.off   = i_req.addr[5:0];
    end

endmodule

`default_nettype wire

/* logic/edge_count_byte.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_count_byte (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_write,
    input  periph_pkg::byte_t i_ui_in,
    output periph_pkg::byte_t o_rdata,
    output periph_pkg::byte_t o_pins
);

    logic              pin_q;     // Pin 0 one cycle ago
    logic              rise;
    periph_pkg::byte_t count;

    assign rise = i_ui_in[0] && !pin_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pin_q <= 1'b0;
            count <= '0;
        end else begin
            pin_q <= i_ui_in[0];
            if (i_write) begin
                count <= '0;  // Any written value clears
            end else if (rise) begin
                count <= count + 8'd1;  // Wraps after 255
            end
        end
    end

    // Count is visible on the bus and on the pins
    assign o_rdata = count;
    assign o_pins  = count;

endmodule

`default_nettype wire

/* logic/gpio_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  periph_pkg::slot_sel_t                            i_sel,
    input  periph_pkg::byte_t                                i_wdata,
    input  periph_pkg::byte_t                                i_ui_in,
    output periph_pkg::word_t                                o_rdata,
    output periph_pkg::byte_t                                o_gpio_out,
    output periph_pkg::pin_func_t [periph_pkg::NUM_PINS-1:0] o_func
);

    periph_pkg::byte_t                                gpio_out;
    periph_pkg::pin_func_t [periph_pkg::NUM_PINS-1:0] func_sel;
    logic                                             wr_en;
    logic                                             func_hit;
    logic [$clog2(periph_pkg::NUM_PINS)-1:0]          func_idx;

    assign wr_en = i_sel.full[periph_pkg::SLOT_GPIO] && i_sel.write;

    // Function selects fill the upper half of the slot, one word per pin
    assign func_hit = ((i_sel.off & 6'h23) == periph_pkg::GPIO_FUNC_OFF);
    assign func_idx = i_sel.off[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && (i_sel.off == periph_pkg::GPIO_OUT_OFF)) begin
            gpio_out <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            func_sel <= {periph_pkg::NUM_PINS{periph_pkg::FUNC_GPIO}};
        end else if (wr_en && func_hit) begin
            func_sel[func_idx] <= i_wdata[4:0];  // Upper data bits ignored
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_sel.off == periph_pkg::GPIO_OUT_OFF) begin
            o_rdata = periph_pkg::word_t'(gpio_out);
        end else if (i_sel.off == periph_pkg::GPIO_IN_OFF) begin
            o_rdata = periph_pkg::word_t'(i_ui_in);  // Live pin state
        end else if (func_hit) begin
            o_rdata = periph_pkg::word_t'(func_sel[func_idx]);
        end
    end

    assign o_gpio_out = gpio_out;
    assign o_func     = func_sel;

endmodule

`default_nettype wire

/* logic/periph_pkg.sv */
`default_nettype none

package periph_pkg;

    localparam int NUM_SLOTS = 16;    // Per bank
    localparam int NUM_PINS  = 8;

    typedef logic [10:0] addr_t;      // Byte address from the core
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;      // Simple-slot data, also one pin vector
    typedef logic [3:0]  slot_idx_t;
    typedef logic [5:0]  reg_off_t;   // Offset inside a 64-byte full slot
    typedef logic [4:0]  pin_func_t;  // Bit 4 picks the simple bank

    // Size code of a core access, 3 means nothing this cycle
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } acc_size_e;

    typedef struct packed {
        addr_t     addr;
        word_t     wdata;
        acc_size_e write_size;
        acc_size_e read_size;
    } bus_req_t;

    typedef struct packed {
        logic [NUM_SLOTS-1:0] full;    // One-hot over 64-byte slots
        logic [NUM_SLOTS-1:0] simple;  // One-hot over 16-byte slots
        logic                 write;
        logic                 read;    // Masked while a read is held
        reg_off_t             off;
    } slot_sel_t;

    typedef struct packed {
        byte_t [NUM_SLOTS-1:0] full;
        byte_t [NUM_SLOTS-1:0] simple;
    } slot_out_t;

    localparam slot_idx_t SLOT_GPIO   = 4'd1;
    localparam slot_idx_t SIMPLE_EDGE = 4'd0;
    localparam slot_idx_t SIMPLE_PWM  = 4'd1;

    localparam reg_off_t GPIO_OUT_OFF  = 6'h00;
    localparam reg_off_t GPIO_IN_OFF   = 6'h04;
    localparam reg_off_t GPIO_FUNC_OFF = 6'h20;  // Pin n at +4n

    // Every pin comes out of reset driven by the GPIO register
    localparam pin_func_t FUNC_GPIO = {1'b0, SLOT_GPIO};

endpackage

`default_nettype wire

/* logic/periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::bus_req_t i_req,
    input  periph_pkg::byte_t    i_ui_in,
    input  logic                 i_read_complete,
    output periph_pkg::byte_t    o_uo_out,
    output periph_pkg::word_t    o_data_out,
    output logic                 o_data_ready
);

    periph_pkg::slot_sel_t                            sel;
    logic                                             busy;
    periph_pkg::word_t                                gpio_rdata;
    periph_pkg::byte_t                                gpio_out;
    periph_pkg::pin_func_t [periph_pkg::NUM_PINS-1:0] func;
    periph_pkg::byte_t                                edge_rdata;
    periph_pkg::byte_t                                edge_pins;
    periph_pkg::byte_t                                pwm_rdata;
    periph_pkg::byte_t                                pwm_pins;
    logic                                             edge_write;
    logic                                             pwm_write;
    periph_pkg::slot_out_t                            slots;

    assign edge_write = sel.write && sel.simple[periph_pkg::SIMPLE_EDGE];
    assign pwm_write  = sel.write && sel.simple[periph_pkg::SIMPLE_PWM];

    // Empty slots drive their pins low
    always_comb begin
        slots                                   = '0;
        slots.full[periph_pkg::SLOT_GPIO]       = gpio_out;
        slots.simple[periph_pkg::SIMPLE_EDGE]   = edge_pins;
        slots.simple[periph_pkg::SIMPLE_PWM]    = pwm_pins;
    end

    bus_decode u_decode (
        .i_req  (i_req),
        .i_busy (busy),
        .o_sel  (sel)
    );

    gpio_regs u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_sel      (sel),
        .i_wdata    (i_req.wdata[7:0]),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_out),
        .o_func     (func)
    );

    edge_count_byte u_edge (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_write (edge_write),
        .i_ui_in (i_ui_in),
        .o_rdata (edge_rdata),
        .o_pins  (edge_pins)
    );

    pwm_byte u_pwm (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_write (pwm_write),
        .i_wdata (i_req.wdata[7:0]),
        .o_rdata (pwm_rdata),
        .o_pins  (pwm_pins)
    );

    read_return u_ret (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_sel           (sel),
        .i_gpio_rdata    (gpio_rdata),
        .i_edge_rdata    (edge_rdata),
        .i_pwm_rdata     (pwm_rdata),
        .i_write_req     (sel.write),
        .i_read_complete (i_read_complete),
        .o_busy          (busy),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

    pin_mux u_pins (
        .i_func   (func),
        .i_slots  (slots),
        .o_uo_out (o_uo_out)
    );

endmodule

`default_nettype wire

/* logic/pin_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module pin_mux (
    input  periph_pkg::pin_func_t [periph_pkg::NUM_PINS-1:0] i_func,
    input  periph_pkg::slot_out_t                            i_slots,
    output periph_pkg::byte_t                                o_uo_out
);

    for (genvar n = 0; n < periph_pkg::NUM_PINS; n++) begin : g_pin
        periph_pkg::slot_idx_t idx;
        logic                  use_simple;

        assign idx        = i_func[n][3:0];
        assign use_simple = i_func[n][4];

        // Pin n only ever takes bit n of the chosen slot
        assign o_uo_out[n] = use_simple ? i_slots.simple[idx][n]
                                        : i_slots.full[idx][n];
    end

endmodule

`default_nettype wire

/* logic/pwm_byte.sv */
`timescale 1ns/1ps
`default_nettype none

module pwm_byte (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_write,
    input  periph_pkg::byte_t i_wdata,
    output periph_pkg::byte_t o_rdata,
    output periph_pkg::byte_t o_pins
);

    periph_pkg::byte_t duty;
    periph_pkg::byte_t cnt;   // Free-running, period of 256 cycles
    logic              pwm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty <= '0;
            cnt  <= '0;
        end else begin
            cnt <= cnt + 8'd1;
            if (i_write) begin
                duty <= i_wdata;
            end
        end
    end

    // High for exactly duty cycles out of every 256
    assign pwm = (cnt < duty);

    assign o_rdata = duty;
    assign o_pins  = {7'b0000000, pwm};  // Only pin 0 carries the waveform

endmodule

`default_nettype wire

/* logic/read_return.sv */
`timescale 1ns/1ps
`default_nettype none

module read_return (
    input  logic                  clk,
    input  logic                  rst_n,
    input  periph_pkg::slot_sel_t i_sel,
    input  periph_pkg::word_t     i_gpio_rdata,
    input  periph_pkg::byte_t     i_edge_rdata,
    input  periph_pkg::byte_t     i_pwm_rdata,
    input  logic                  i_write_req,
    input  logic                  i_read_complete,
    output logic                  o_busy,
    output periph_pkg::word_t     o_data_out,
    output logic                  o_data_ready
);

    typedef enum logic {
        IDLE,
        HOLD
    } ret_state_e;

    ret_state_e        state;
    periph_pkg::word_t rdata_mux;
    logic              ready_mux;
    logic              accept;
    periph_pkg::word_t data_q;
    logic              ready_q;

    // Simple-slot bytes are zero-extended, empty slots read zero
    always_comb begin
        rdata_mux = '0;
        if (i_sel.full[periph_pkg::SLOT_GPIO]) begin
            rdata_mux = i_gpio_rdata;
        end else if (i_sel.simple[periph_pkg::SIMPLE_EDGE]) begin
            rdata_mux = periph_pkg::word_t'(i_edge_rdata);
        end else if (i_sel.simple[periph_pkg::SIMPLE_PWM]) begin
            rdata_mux = periph_pkg::word_t'(i_pwm_rdata);
        end
    end

    // Simple slots always answer, of the full slots only GPIO is populated
    assign ready_mux = (|i_sel.simple) || i_sel.full[periph_pkg::SLOT_GPIO];
    assign accept    = i_sel.read && ready_mux && (state == IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            ready_q <= 1'b0;
        end else begin
            ready_q <= accept;  // One-cycle pulse per captured read
            case (state)
                IDLE: if (accept) state <= HOLD;
                HOLD: if (i_read_complete) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= rdata_mux;
        end
    end

    assign o_busy       = (state == HOLD);
    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || i_write_req;  // Writes complete at once

    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (state == HOLD) |=> $stable(o_data_out))
        else $error("held read data changed before read complete");

endmodule

`default_nettype wire

/* sim/periph_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_tb;

    typedef enum logic [3:0] {
        OP_WRITE,
        OP_READ,
        OP_HOLD_READ,  // Read and leave the answer held
        OP_HELD,       // Masked reads while held, then check held data
        OP_COMPLETE,
        OP_INPUT,
        OP_PULSE,      // data = number of pulses on input pin 0
        OP_PINS,
        OP_PWM         // data = window in cycles, exp = high cycles
    } op_e;

    typedef struct packed {
        op_e                 op;
        periph_pkg::addr_t   addr;
        periph_pkg::word_t   data;
        periph_pkg::word_t   exp;
    } row_t;

    logic                 clk;
    logic                 rst_n;
    periph_pkg::bus_req_t i_req;
    periph_pkg::byte_t    i_ui_in;
    logic                 i_read_complete;
    periph_pkg::byte_t    o_uo_out;
    periph_pkg::word_t    o_data_out;
    logic                 o_data_ready;

    int   errors;
    int   checks;
    row_t rows[$];

    periph_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (i_req),
        .i_ui_in         (i_ui_in),
        .i_read_complete (i_read_complete),
        .o_uo_out        (o_uo_out),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic periph_pkg::bus_req_t idle_req();
        periph_pkg::bus_req_t r;
        r            = '0;
        r.write_size = periph_pkg::ACC_NONE;
        r.read_size  = periph_pkg::ACC_NONE;
        return r;
    endfunction

    task automatic check_word(input string name, input periph_pkg::word_t exp,
                              input periph_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic check_pins(input string name, input periph_pkg::byte_t exp,
                              input periph_pkg::byte_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected 0x%02h, actual 0x%02h", name, exp, act);
        end
    endtask

    task automatic add_row(input op_e op, input periph_pkg::addr_t a,
                           input periph_pkg::word_t d, input periph_pkg::word_t e);
        rows.push_back({op, a, d, e});
    endtask

    task automatic bus_write(input string name, input periph_pkg::addr_t a,
                             input periph_pkg::word_t d);
        @(posedge clk);
        i_req.addr       <= a;
        i_req.wdata      <= d;
        i_req.write_size <= periph_pkg::ACC_WORD;
        i_req.read_size  <= periph_pkg::ACC_NONE;
        @(negedge clk);
        if (!o_data_ready) begin
            errors++;
            $display("%s: o_data_ready stayed low during a write", name);
        end
        @(posedge clk);  // Write lands on this edge
        i_req <= idle_req();
    endtask

    task automatic bus_read(input string name, input periph_pkg::addr_t a,
                            input periph_pkg::word_t exp, input logic complete);
        logic got;
        int   cyc;
        got = 1'b0;
        @(posedge clk);
        i_req.addr       <= a;
        i_req.write_size <= periph_pkg::ACC_NONE;
        i_req.read_size  <= periph_pkg::ACC_WORD;
        for (cyc = 0; cyc < 20 && !got; cyc++) begin
            @(negedge clk);
            got = o_data_ready;
        end
        if (!got) begin
            errors++;
            $display("%s: o_data_ready did not rise within 20 cycles", name);
        end else begin
            check_word(name, exp, o_data_out);
        end
        @(posedge clk);  // Core drops the request once it has seen ready
        i_req <= idle_req();
        if (complete) begin
            i_read_complete <= 1'b1;
            @(posedge clk);
            i_read_complete <= 1'b0;
        end
    endtask

    // Two cycles high, two low, so every pulse is a clean rising edge
    task automatic pulse_pin0(input int k);
        repeat (k) begin
            @(posedge clk);
            i_ui_in[0] <= 1'b1;
            repeat (2) @(posedge clk);
            i_ui_in[0] <= 1'b0;
            @(posedge clk);
        end
    endtask

    task automatic count_pwm_high(input int cycles, output periph_pkg::word_t n);
        n = '0;
        repeat (cycles) begin
            @(negedge clk);
            if (o_uo_out[0]) n++;
        end
    endtask

    task automatic build_table();
        periph_pkg::addr_t gpio_base;
        periph_pkg::addr_t out_a;
        periph_pkg::addr_t func_a;
        periph_pkg::addr_t edge_a;
        periph_pkg::addr_t pwm_a;
        gpio_base = periph_pkg::addr_t'({periph_pkg::SLOT_GPIO, 6'd0});  // 64-byte slots
        out_a     = gpio_base + periph_pkg::GPIO_OUT_OFF;
        func_a    = gpio_base + periph_pkg::GPIO_FUNC_OFF;
        edge_a    = 11'h400 | {periph_pkg::SIMPLE_EDGE, 4'h0};  // 16-byte slots
        pwm_a     = 11'h400 | {periph_pkg::SIMPLE_PWM, 4'h0};

        // Reset state
        add_row(OP_READ, out_a, 0, 0);
        for (int n = 0; n < 8; n++) begin
            add_row(OP_READ, func_a + 4 * n, 0, 32'(periph_pkg::FUNC_GPIO));
        end
        add_row(OP_READ, edge_a, 0, 0);
        add_row(OP_READ, pwm_a, 0, 0);
        add_row(OP_PINS, 0, 0, 0);
        // GPIO output and input registers
        add_row(OP_WRITE, out_a, 32'ha5, 0);
        add_row(OP_READ, out_a, 0, 32'ha5);
        add_row(OP_PINS, 0, 0, 32'ha5);
        add_row(OP_INPUT, 0, 32'h3c, 0);
        add_row(OP_READ, gpio_base + periph_pkg::GPIO_IN_OFF, 0, 32'h3c);
        add_row(OP_INPUT, 0, 32'h00, 0);
        // Edge counter, pins 2..7 routed to simple slot 0
        add_row(OP_PULSE, 0, 5, 0);
        add_row(OP_READ, edge_a, 0, 5);
        for (int n = 2; n < 8; n++) begin
            add_row(OP_WRITE, func_a + 4 * n, {27'd0, 1'b1, periph_pkg::SIMPLE_EDGE}, 0);
        end
        add_row(OP_PULSE, 0, 41, 0);
        add_row(OP_PINS, 0, 0, (46 & 32'hfc) | (32'ha5 & 32'h03));
        add_row(OP_READ, edge_a, 0, 46);
        add_row(OP_WRITE, edge_a, 32'h77, 0);
        add_row(OP_READ, edge_a, 0, 0);
        add_row(OP_PINS, 0, 0, 32'ha5 & 32'h03);
        // PWM on pin 0
        add_row(OP_WRITE, func_a, {27'd0, 1'b1, periph_pkg::SIMPLE_PWM}, 0);
        add_row(OP_PWM, 0, 300, 0);
        add_row(OP_WRITE, pwm_a, 32'h80, 0);
        add_row(OP_READ, pwm_a, 0, 32'h80);
        add_row(OP_PWM, 0, 256, 128);
        // Held read survives a register change and masked reads
        add_row(OP_WRITE, out_a, 32'h5a, 0);
        add_row(OP_HOLD_READ, out_a, 0, 32'h5a);
        add_row(OP_WRITE, out_a, 32'hc3, 0);
        add_row(OP_HELD, out_a, 0, 32'h5a);
        add_row(OP_COMPLETE, 0, 0, 0);
        add_row(OP_READ, out_a, 0, 32'hc3);
    endtask

    initial begin
        row_t              r;
        string             name;
        periph_pkg::word_t n;
        errors          = 0;
        checks          = 0;
        rst_n           = 1'b0;
        i_req           = idle_req();
        i_ui_in         = '0;
        i_read_complete = 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            r    = rows[i];
            name = $sformatf("row %0d %s", i, r.op.name());
            case (r.op)
                OP_WRITE:     bus_write(name, r.addr, r.data);
                OP_READ:      bus_read(name, r.addr, r.exp, 1'b1);
                OP_HOLD_READ: bus_read(name, r.addr, r.exp, 1'b0);
                OP_HELD: begin
                    @(posedge clk);
                    i_req.addr      <= r.addr;
                    i_req.read_size <= periph_pkg::ACC_WORD;
                    repeat (3) @(posedge clk);
                    i_req <= idle_req();
                    @(negedge clk);
                    check_word(name, r.exp, o_data_out);
                end
                OP_COMPLETE: begin
                    @(posedge clk);
                    i_read_complete <= 1'b1;
                    @(posedge clk);
                    i_read_complete <= 1'b0;
                end
                OP_INPUT: begin
                    @(posedge clk);
                    i_ui_in <= r.data[7:0];
                end
                OP_PULSE: pulse_pin0(r.data);
                OP_PINS: begin
                    @(negedge clk);
                    check_pins(name, r.exp[7:0], o_uo_out);
                end
                OP_PWM: begin
                    count_pwm_high(r.data, n);
                    check_word(name, r.exp, n);
                end
                default: begin
                    errors++;
                    $display("%s: unknown table operation", name);
                end
            endcase
        end

        repeat (2) @(posedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
